// ==== exu_pkg.sv ====
`default_nettype none

package exu_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////

   localparam int xlen      = 32;
   localparam int reg_idx_w = 5;
   localparam int exccode_w = 6;

   // interrupt cause as reported to the csr side
   localparam logic [exccode_w-1:0] exc_intr = {exccode_w{1'b0}};

   ////////////////////////////////////////////////////////////
   // encodings
   ////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5,
      ALU_SLL = 3'd6
   } alu_op_t;

   // stall tracking for one outstanding load/store
   typedef enum logic {
      LSU_IDLE = 1'b0,
      LSU_WAIT = 1'b1
   } lsu_state_t;

endpackage

`default_nettype wire

// ==== exu_bypass.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_bypass (
   input  logic [exu_pkg::reg_idx_w-1:0] rs1,
   input  logic [exu_pkg::reg_idx_w-1:0] rs2,
   input  logic [exu_pkg::xlen-1:0]      rs1_data,
   input  logic [exu_pkg::xlen-1:0]      rs2_data,

   input  logic [exu_pkg::reg_idx_w-1:0] mem_rd,
   input  logic [exu_pkg::reg_idx_w-1:0] wb_rd,
   input  logic                          mem_wen,
   input  logic                          wb_wen,
   input  logic [exu_pkg::xlen-1:0]      mem_data,
   input  logic [exu_pkg::xlen-1:0]      wb_data,

   output logic [exu_pkg::xlen-1:0]      opa,
   output logic [exu_pkg::xlen-1:0]      opb
);

   // r0 is hardwired so a write to it never forwards
   function automatic logic fwd_hit(
      input logic [exu_pkg::reg_idx_w-1:0] rs,
      input logic [exu_pkg::reg_idx_w-1:0] rd,
      input logic                          wen
   );
      return wen && (rs == rd) && (rs != '0);
   endfunction

   logic rs1_sel_m;
   logic rs1_sel_w;
   logic rs2_sel_m;
   logic rs2_sel_w;

   assign rs1_sel_m = fwd_hit(rs1, mem_rd, mem_wen);
   assign rs1_sel_w = fwd_hit(rs1, wb_rd, wb_wen);
   assign rs2_sel_m = fwd_hit(rs2, mem_rd, mem_wen);
   assign rs2_sel_w = fwd_hit(rs2, wb_rd, wb_wen);

   // memory stage holds the younger value, so it wins
   assign opa = rs1_sel_m ? mem_data :
                rs1_sel_w ? wb_data  : rs1_data;

   assign opb = rs2_sel_m ? mem_data :
                rs2_sel_w ? wb_data  : rs2_data;

endmodule

`default_nettype wire

// ==== exu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
   input  exu_pkg::alu_op_t         op,
   input  logic [exu_pkg::xlen-1:0] opa,
   input  logic [exu_pkg::xlen-1:0] opb,
   input  logic [exu_pkg::xlen-1:0] imm,
   input  logic                     b_imm,

   output logic [exu_pkg::xlen-1:0] alu_res,

   output logic [exu_pkg::xlen-1:0] lsu_base,
   output logic [exu_pkg::xlen-1:0] lsu_offset,
   output logic [exu_pkg::xlen-1:0] lsu_wdata
);

   ////////////////////////////////////////////////////////////
   // operand b
   ////////////////////////////////////////////////////////////

   logic [exu_pkg::xlen-1:0] src_b;
   logic                     lt_signed;

   assign src_b = b_imm ? imm : opb;

   assign lt_signed = $signed(opa) < $signed(src_b);

   ////////////////////////////////////////////////////////////
   // result
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (op)
         exu_pkg::ALU_ADD: alu_res = opa + src_b;
         exu_pkg::ALU_SUB: alu_res = opa - src_b;
         exu_pkg::ALU_AND: alu_res = opa & src_b;
         exu_pkg::ALU_OR:  alu_res = opa | src_b;
         exu_pkg::ALU_XOR: alu_res = opa ^ src_b;
         exu_pkg::ALU_SLT: alu_res = {{(exu_pkg::xlen-1){1'b0}}, lt_signed};
         // shift amount from the low five bits only
         exu_pkg::ALU_SLL: alu_res = opa << src_b[4:0];
         default:          alu_res = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // load/store hand-off
   ////////////////////////////////////////////////////////////

   // base from rs1, offset is imm or rs2, store data always rs2
   assign lsu_base   = opa;
   assign lsu_offset = src_b;
   assign lsu_wdata  = opb;

endmodule

`default_nettype wire

// ==== exu_commit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_commit (
   input  logic                          clk,
   input  logic                          rst_n,

   // execute stage
   input  logic [exu_pkg::xlen-1:0]      alu_res,
   input  logic [exu_pkg::reg_idx_w-1:0] rd,
   input  logic                          alu_wen,
   input  logic                          kill,

   // load/store return, valid at the memory stage
   input  logic                          lsu_finish,
   input  logic [exu_pkg::xlen-1:0]      lsu_rdata,
   input  logic [exu_pkg::reg_idx_w-1:0] lsu_rd_m,
   input  logic                          lsu_wen_m,

   output logic [exu_pkg::reg_idx_w-1:0] mem_rd,
   output logic                          mem_wen,
   output logic [exu_pkg::xlen-1:0]      mem_data,

   output logic [exu_pkg::reg_idx_w-1:0] wb_rd,
   output logic                          wb_wen,
   output logic [exu_pkg::xlen-1:0]      wb_data
);

   logic [exu_pkg::xlen-1:0]      alu_res_m;
   logic [exu_pkg::reg_idx_w-1:0] alu_rd_m;
   logic                          alu_wen_m;

   ////////////////////////////////////////////////////////////
   // execute to memory
   ////////////////////////////////////////////////////////////

   // a killed instruction must not reach the register file
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         alu_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_wen & ~kill;
      end
   end

   always_ff @(posedge clk) begin
      alu_res_m <= alu_res;
      alu_rd_m  <= rd;
   end

   ////////////////////////////////////////////////////////////
   // memory stage result select
   ////////////////////////////////////////////////////////////

   // lsu keeps its own rd since its latency is not fixed
   assign mem_rd   = lsu_finish ? lsu_rd_m  : alu_rd_m;
   assign mem_data = lsu_finish ? lsu_rdata : alu_res_m;

   // either source may claim the write port
   assign mem_wen  = alu_wen_m | (lsu_wen_m & lsu_finish);

   ////////////////////////////////////////////////////////////
   // memory to writeback
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_wen <= 1'b0;
      end else begin
         wb_wen <= mem_wen;
      end
   end

   always_ff @(posedge clk) begin
      wb_rd   <= mem_rd;
      wb_data <= mem_data;
   end

   // the issue stall keeps alu results out of the finish cycle,
   // otherwise one of the two writes would be dropped
   a_finish_no_alu_m: assert property (
      @(posedge clk) disable iff (!rst_n)
      lsu_finish |-> !alu_wen_m
   ) else $error("lsu_finish collides with an alu write at the memory stage");

endmodule

`default_nettype wire

// ==== exu_trap_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_trap_ctrl (
   input  logic                          clk,
   input  logic                          rst_n,

   input  logic                          issue_valid,
   input  logic                          lsu_valid,
   input  logic                          lsu_finish,

   input  logic                          timer_intr,
   input  logic                          ext_intr,
   input  logic                          crmd_ie,

   input  logic                          exception,
   input  logic [exu_pkg::exccode_w-1:0] exccode,
   input  logic                          lsu_ale,

   output logic                          kill,
   output logic                          except,
   output logic [exu_pkg::exccode_w-1:0] exccode_out,
   output logic                          stall_req
);

   logic                issue_valid_q;
   logic                intr_pending;
   logic                intr_fire;
   logic                lsu_issue;
   exu_pkg::lsu_state_t lsu_state;
   exu_pkg::lsu_state_t lsu_state_nxt;

   ////////////////////////////////////////////////////////////
   // interrupt
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_valid_q <= 1'b0;
      end else begin
         issue_valid_q <= issue_valid;
      end
   end

   assign intr_pending = (timer_intr | ext_intr) & crmd_ie;

   // only taken on the first issue after an idle cycle
   assign intr_fire = intr_pending & issue_valid & ~issue_valid_q;

   assign kill = intr_fire;

   // interrupt has priority, the faulting instruction is replayed later
   assign except      = intr_fire | exception | lsu_ale;
   assign exccode_out = intr_fire ? exu_pkg::exc_intr : exccode;

   ////////////////////////////////////////////////////////////
   // load/store stall
   ////////////////////////////////////////////////////////////

   assign lsu_issue = issue_valid & lsu_valid & ~kill;

   always_comb begin
      lsu_state_nxt = lsu_state;
      case (lsu_state)
         exu_pkg::LSU_IDLE: if (lsu_issue) lsu_state_nxt = exu_pkg::LSU_WAIT;
         exu_pkg::LSU_WAIT: if (lsu_finish) lsu_state_nxt = exu_pkg::LSU_IDLE;
         default:           lsu_state_nxt = exu_pkg::LSU_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lsu_state <= exu_pkg::LSU_IDLE;
      end else begin
         lsu_state <= lsu_state_nxt;
      end
   end

   // high from the issue cycle up to and including the finish cycle
   assign stall_req = (lsu_state == exu_pkg::LSU_WAIT) | lsu_issue;

   a_finish_in_wait: assert property (
      @(posedge clk) disable iff (!rst_n)
      lsu_finish |-> (lsu_state == exu_pkg::LSU_WAIT)
   ) else $error("lsu_finish without an outstanding load/store");

endmodule

`default_nettype wire

// ==== exu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_top (
   input  logic                          clk,
   input  logic                          rst_n,

   // issue
   input  logic                          issue_valid,
   input  exu_pkg::alu_op_t              alu_op,
   input  logic [exu_pkg::reg_idx_w-1:0] rs1,
   input  logic [exu_pkg::reg_idx_w-1:0] rs2,
   input  logic [exu_pkg::xlen-1:0]      rs1_data,
   input  logic [exu_pkg::xlen-1:0]      rs2_data,
   input  logic [exu_pkg::xlen-1:0]      imm,
   input  logic                          b_imm,
   input  logic [exu_pkg::reg_idx_w-1:0] rd,
   input  logic                          alu_wen,
   input  logic                          lsu_valid,

   // load/store unit return
   input  logic                          lsu_finish,
   input  logic [exu_pkg::xlen-1:0]      lsu_rdata,
   input  logic [exu_pkg::reg_idx_w-1:0] lsu_rd_m,
   input  logic                          lsu_wen_m,
   input  logic                          lsu_ale,

   // exceptions and interrupts
   input  logic                          exception,
   input  logic [exu_pkg::exccode_w-1:0] exccode,
   input  logic                          timer_intr,
   input  logic                          ext_intr,
   input  logic                          crmd_ie,

   output logic                          lsu_req,
   output logic [exu_pkg::xlen-1:0]      lsu_base,
   output logic [exu_pkg::xlen-1:0]      lsu_offset,
   output logic [exu_pkg::xlen-1:0]      lsu_wdata,

   output logic                          except,
   output logic [exu_pkg::exccode_w-1:0] exccode_out,
   output logic                          stall_req,

   // register file write port
   output logic                          rf_wen,
   output logic [exu_pkg::reg_idx_w-1:0] rf_rd,
   output logic [exu_pkg::xlen-1:0]      rf_wdata
);

   logic [exu_pkg::xlen-1:0]      opa;
   logic [exu_pkg::xlen-1:0]      opb;
   logic [exu_pkg::xlen-1:0]      alu_res;
   logic                          kill;
   logic [exu_pkg::reg_idx_w-1:0] mem_rd;
   logic                          mem_wen;
   logic [exu_pkg::xlen-1:0]      mem_data;

   exu_bypass u_bypass (
      .rs1      (rs1),
      .rs2      (rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .mem_rd   (mem_rd),
      .wb_rd    (rf_rd),
      .mem_wen  (mem_wen),
      .wb_wen   (rf_wen),
      .mem_data (mem_data),
      .wb_data  (rf_wdata),
      .opa      (opa),
      .opb      (opb)
   );

   exu_alu u_alu (
      .op         (alu_op),
      .opa        (opa),
      .opb        (opb),
      .imm        (imm),
      .b_imm      (b_imm),
      .alu_res    (alu_res),
      .lsu_base   (lsu_base),
      .lsu_offset (lsu_offset),
      .lsu_wdata  (lsu_wdata)
   );

   // killed load/store never goes out
   assign lsu_req = lsu_valid & issue_valid & ~kill;

   exu_commit u_commit (
      .clk        (clk),
      .rst_n      (rst_n),
      .alu_res    (alu_res),
      .rd         (rd),
      .alu_wen    (alu_wen),
      .kill       (kill),
      .lsu_finish (lsu_finish),
      .lsu_rdata  (lsu_rdata),
      .lsu_rd_m   (lsu_rd_m),
      .lsu_wen_m  (lsu_wen_m),
      .mem_rd     (mem_rd),
      .mem_wen    (mem_wen),
      .mem_data   (mem_data),
      .wb_rd      (rf_rd),
      .wb_wen     (rf_wen),
      .wb_data    (rf_wdata)
   );

   exu_trap_ctrl u_trap_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .lsu_valid   (lsu_valid),
      .lsu_finish  (lsu_finish),
      .timer_intr  (timer_intr),
      .ext_intr    (ext_intr),
      .crmd_ie     (crmd_ie),
      .exception   (exception),
      .exccode     (exccode),
      .lsu_ale     (lsu_ale),
      .kill        (kill),
      .except      (except),
      .exccode_out (exccode_out),
      .stall_req   (stall_req)
   );

endmodule

`default_nettype wire

// ==== tb_exu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exu;

   logic                          clk;
   logic                          rst_n;
   logic                          issue_valid;
   exu_pkg::alu_op_t              alu_op;
   logic [exu_pkg::reg_idx_w-1:0] rs1;
   logic [exu_pkg::reg_idx_w-1:0] rs2;
   logic [exu_pkg::xlen-1:0]      rs1_data;
   logic [exu_pkg::xlen-1:0]      rs2_data;
   logic [exu_pkg::xlen-1:0]      imm;
   logic                          b_imm;
   logic [exu_pkg::reg_idx_w-1:0] rd;
   logic                          alu_wen;
   logic                          lsu_valid;
   logic                          lsu_finish;
   logic [exu_pkg::xlen-1:0]      lsu_rdata;
   logic [exu_pkg::reg_idx_w-1:0] lsu_rd_m;
   logic                          lsu_wen_m;
   logic                          lsu_ale;
   logic                          exception;
   logic [exu_pkg::exccode_w-1:0] exccode;
   logic                          timer_intr;
   logic                          ext_intr;
   logic                          crmd_ie;
   logic                          lsu_req;
   logic [exu_pkg::xlen-1:0]      lsu_base;
   logic [exu_pkg::xlen-1:0]      lsu_offset;
   logic [exu_pkg::xlen-1:0]      lsu_wdata;
   logic                          except;
   logic [exu_pkg::exccode_w-1:0] exccode_out;
   logic                          stall_req;
   logic                          rf_wen;
   logic [exu_pkg::reg_idx_w-1:0] rf_rd;
   logic [exu_pkg::xlen-1:0]      rf_wdata;

   // fields of the current line of exu_cases.txt
   string       c_name;
   string       c_kind;
   int          c_op;
   int          c_rs1;
   int          c_rs2;
   int          c_bimm;
   int          c_rd;
   int          c_dep;
   int          c_lat;
   int          c_tmr;
   int          c_ext;
   int          c_ie;
   int          c_exc;
   int          c_ale;
   logic [31:0] c_d1;
   logic [31:0] c_d2;
   logic [31:0] c_imm;
   logic [31:0] c_ldata;
   logic [31:0] c_code;
   logic [31:0] c_expect;

   string case_lines[$];
   int    max_lat;
   int    n_pass;
   int    n_fail;
   bit    loaded;
   bit    case_bad;

   exu_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .alu_op      (alu_op),
      .rs1         (rs1),
      .rs2         (rs2),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .imm         (imm),
      .b_imm       (b_imm),
      .rd          (rd),
      .alu_wen     (alu_wen),
      .lsu_valid   (lsu_valid),
      .lsu_finish  (lsu_finish),
      .lsu_rdata   (lsu_rdata),
      .lsu_rd_m    (lsu_rd_m),
      .lsu_wen_m   (lsu_wen_m),
      .lsu_ale     (lsu_ale),
      .exception   (exception),
      .exccode     (exccode),
      .timer_intr  (timer_intr),
      .ext_intr    (ext_intr),
      .crmd_ie     (crmd_ie),
      .lsu_req     (lsu_req),
      .lsu_base    (lsu_base),
      .lsu_offset  (lsu_offset),
      .lsu_wdata   (lsu_wdata),
      .except      (except),
      .exccode_out (exccode_out),
      .stall_req   (stall_req),
      .rf_wen      (rf_wen),
      .rf_rd       (rf_rd),
      .rf_wdata    (rf_wdata)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   // alu result from the opcode definitions
   function automatic logic [31:0] ref_alu(input int op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic [31:0] r;
      case (op)
         exu_pkg::ALU_ADD: r = a + b;
         exu_pkg::ALU_SUB: r = a + ~b + 32'd1;
         exu_pkg::ALU_AND: r = a & b;
         exu_pkg::ALU_OR:  r = a | b;
         exu_pkg::ALU_XOR: r = a ^ b;
         // differing signs decide on their own
         exu_pkg::ALU_SLT: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
         exu_pkg::ALU_SLL: r = a << b[4:0];
         default:          r = 32'hxxxxxxxx;
      endcase
      return r;
   endfunction

   task automatic clear_issue();
      issue_valid = 1'b0;
      alu_wen     = 1'b0;
      lsu_valid   = 1'b0;
      exception   = 1'b0;
      lsu_ale     = 1'b0;
      timer_intr  = 1'b0;
      ext_intr    = 1'b0;
      crmd_ie     = 1'b0;
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Error: %s %s expected %h actual %h", c_name, what, exp, act);
      case_bad = 1'b1;
   endtask

   task automatic note_problem(input string msg);
      $display("%s: %s", c_name, msg);
      case_bad = 1'b1;
   endtask

   task automatic record_result();
      if (case_bad) begin
         n_fail = n_fail + 1;
         $display("FAIL %s", c_name);
      end else begin
         n_pass = n_pass + 1;
         $display("PASS %s", c_name);
      end
   endtask

   task automatic parse_case(input string line, output bit ok);
      int n;
      n = $sscanf(line, "%s %s %d %d %h %d %h %h %d %d %d %d %h %d %d %d %d %d %h %h",
                  c_name, c_kind, c_op, c_rs1, c_d1, c_rs2, c_d2, c_imm, c_bimm, c_rd,
                  c_dep, c_lat, c_ldata, c_tmr, c_ext, c_ie, c_exc, c_ale, c_code,
                  c_expect);
      ok = (n == 20);
   endtask

   ////////////////////////////////////////////////////////////
   // one case
   ////////////////////////////////////////////////////////////

   task automatic run_case();
      logic [31:0] a_val;
      logic [31:0] b_reg;
      logic [31:0] a_drv;
      logic [31:0] b_drv;
      logic [31:0] model;
      logic        is_lsu;
      case_bad = 1'b0;
      a_val = c_d1;
      b_reg = c_d2;
      a_drv = c_d1;
      b_drv = c_d2;
      // dependent source gets a stale register value that only forwarding fixes
      if (c_dep != 0) begin
         a_val = (c_rs1 == 0) ? 32'd0 : c_d1;
         a_drv = (c_rs1 == 0) ? 32'd0 : ~c_d1;
         if (c_rs2 == c_rs1) begin
            b_reg = a_val;
            b_drv = a_drv;
         end
      end
      is_lsu = (c_kind == "lsu") || (c_kind != "alu" && c_lat != 0);
      if (c_kind == "alu")
         model = ref_alu(c_op, a_val, c_bimm ? c_imm : b_reg);
      else if (c_kind == "lsu")
         model = c_ldata;
      else if (c_kind == "intr")
         model = exu_pkg::exc_intr;
      else
         model = c_code;
      if (model !== c_expect)
         note_problem("expected value in the case file disagrees with the reference model");

      // idle gap drains the pipe and arms interrupt sampling
      repeat (2) @(negedge clk);
      if (c_dep != 0) begin
         // producer writes d1 into the consumer's rs1
         @(negedge clk);
         issue_valid = 1'b1;
         alu_op      = exu_pkg::ALU_ADD;
         rs1         = '0;
         rs2         = '0;
         rs1_data    = '0;
         rs2_data    = '0;
         imm         = c_d1;
         b_imm       = 1'b1;
         rd          = c_rs1[4:0];
         alu_wen     = 1'b1;
         if (c_dep == 2) begin
            @(negedge clk);
            clear_issue();
         end
      end

      @(negedge clk);
      issue_valid = 1'b1;
      alu_op      = exu_pkg::alu_op_t'(c_op[2:0]);
      rs1         = c_rs1[4:0];
      rs2         = c_rs2[4:0];
      rs1_data    = a_drv;
      rs2_data    = b_drv;
      imm         = c_imm;
      b_imm       = c_bimm[0];
      rd          = c_rd[4:0];
      alu_wen     = (c_kind == "alu") || (c_kind == "intr");
      lsu_valid   = is_lsu;
      timer_intr  = c_tmr[0];
      ext_intr    = c_ext[0];
      crmd_ie     = c_ie[0];
      exception   = c_exc[0];
      lsu_ale     = c_ale[0];
      exccode     = c_code[5:0];
      #2;
      if (c_kind == "alu" || c_kind == "lsu") begin
         if (except !== 1'b0)
            note_problem("except raised on a clean instruction");
      end else begin
         if (except !== 1'b1)
            note_problem("except not raised in the issue cycle");
         if (exccode_out !== c_expect[5:0])
            report_mismatch("exccode_out", c_expect, exccode_out);
      end
      if (c_kind == "intr") begin
         if (lsu_req !== 1'b0 || stall_req !== 1'b0)
            note_problem("killed instruction still reached the load/store unit");
      end
      if (c_kind == "lsu") begin
         if (lsu_req !== 1'b1)
            note_problem("lsu_req missing in the issue cycle");
         if (lsu_base !== a_val)
            report_mismatch("lsu_base", a_val, lsu_base);
         if (lsu_offset !== (c_bimm ? c_imm : b_reg))
            report_mismatch("lsu_offset", c_bimm ? c_imm : b_reg, lsu_offset);
         if (lsu_wdata !== b_reg)
            report_mismatch("lsu_wdata", b_reg, lsu_wdata);
      end
      if (is_lsu && c_kind != "intr" && stall_req !== 1'b1)
         note_problem("stall_req low in the issue cycle");
      @(negedge clk);
      clear_issue();

      if (is_lsu && c_kind != "intr") begin
         // load/store unit model finishes after the given latency
         repeat (c_lat - 1) begin
            #2;
            if (stall_req !== 1'b1)
               note_problem("stall_req dropped before lsu_finish");
            @(negedge clk);
         end
         lsu_finish = 1'b1;
         lsu_rdata  = c_ldata;
         lsu_rd_m   = c_rd[4:0];
         lsu_wen_m  = (c_kind == "lsu");
         #2;
         if (stall_req !== 1'b1)
            note_problem("stall_req low in the lsu_finish cycle");
         @(negedge clk);
         lsu_finish = 1'b0;
         lsu_wen_m  = 1'b0;
         #2;
         if (stall_req !== 1'b0)
            note_problem("stall state did not return to idle after lsu_finish");
         if (c_kind == "lsu") begin
            if (rf_wen !== 1'b1)
               note_problem("no register write in the cycle after lsu_finish");
            if (rf_rd !== c_rd[4:0])
               report_mismatch("rf_rd", c_rd, rf_rd);
            if (rf_wdata !== c_expect)
               report_mismatch("rf_wdata", c_expect, rf_wdata);
         end else if (rf_wen !== 1'b0) begin
            note_problem("faulting load/store wrote a register");
         end
      end else if (c_kind == "alu") begin
         @(negedge clk);
         #2;
         if (rf_wen !== 1'b1)
            note_problem("no register write two cycles after issue");
         if (rf_rd !== c_rd[4:0])
            report_mismatch("rf_rd", c_rd, rf_rd);
         if (rf_wdata !== c_expect)
            report_mismatch("rf_wdata", c_expect, rf_wdata);
      end else if (c_kind == "intr") begin
         repeat (3) begin
            #2;
            if (rf_wen !== 1'b0)
               note_problem("register write after an interrupt kill");
            @(negedge clk);
         end
      end else begin
         #2;
         if (stall_req !== 1'b0)
            note_problem("stall state not idle after the exception");
      end

      record_result();
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      string line;
      int    fd;
      int    got;
      bit    ok;
      clk        = 1'b0;
      rst_n      = 1'b0;
      alu_op     = exu_pkg::ALU_ADD;
      rs1        = '0;
      rs2        = '0;
      rs1_data   = '0;
      rs2_data   = '0;
      imm        = '0;
      b_imm      = 1'b0;
      rd         = '0;
      exccode    = '0;
      lsu_finish = 1'b0;
      lsu_rdata  = '0;
      lsu_rd_m   = '0;
      lsu_wen_m  = 1'b0;
      clear_issue();
      n_pass  = 0;
      n_fail  = 0;
      max_lat = 0;

      fd = $fopen("exu_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open exu_cases.txt");
         n_fail = 1;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
               parse_case(line, ok);
               if (ok) begin
                  case_lines.push_back(line);
                  if (c_lat > max_lat)
                     max_lat = c_lat;
               end else begin
                  $display("malformed line in exu_cases.txt: %s", line);
                  n_fail = n_fail + 1;
               end
            end
         end
         $fclose(fd);
      end
      loaded = 1'b1;

      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      #2;
      c_name   = "reset";
      case_bad = 1'b0;
      if (rf_wen !== 1'b0 || stall_req !== 1'b0 || lsu_req !== 1'b0 || except !== 1'b0)
         note_problem("outputs not low after reset");
      record_result();

      foreach (case_lines[i]) begin
         parse_case(case_lines[i], ok);
         run_case();
      end

      $display("tests: %0d passed, %0d failed", n_pass, n_fail);
      if (n_fail == 0 && n_pass > 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // watchdog budget covers reset plus a fixed count per case
   initial begin
      wait (loaded);
      repeat (24 + case_lines.size() * (max_lat + 10)) @(posedge clk);
      $display("timeout: the cases did not finish in the expected number of cycles");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== exu_cases.txt ====
# name kind op rs1 rs1_data rs2 rs2_data imm b_imm rd dep lat load_data timer ext ie exc ale exccode expected
# data and codes in hex, dep 1 = back-to-back producer, dep 2 = one idle cycle between
add_reg      alu  0 1  00000005 2  00000007 00000000 0 3  0 0 00000000 0 0 0 0 0 00 0000000c
add_imm      alu  0 1  0000000a 2  deadbeef fffffffe 1 4  0 0 00000000 0 0 0 0 0 00 00000008
sub_reg      alu  1 5  00000010 6  00000020 00000000 0 7  0 0 00000000 0 0 0 0 0 00 fffffff0
and_reg      alu  2 8  f0f0ff00 9  ff00f0f0 00000000 0 10 0 0 00000000 0 0 0 0 0 00 f000f000
or_imm       alu  3 11 12340000 12 ffffffff 00005678 1 13 0 0 00000000 0 0 0 0 0 00 12345678
xor_reg      alu  4 14 aaaa5555 15 ffff0000 00000000 0 16 0 0 00000000 0 0 0 0 0 00 55555555
slt_neg      alu  5 17 ffffff80 18 00000001 00000000 0 19 0 0 00000000 0 0 0 0 0 00 00000001
slt_pos      alu  5 17 7fffffff 18 80000000 00000000 0 20 0 0 00000000 0 0 0 0 0 00 00000000
sll_imm      alu  6 21 00000003 22 00000000 00000024 1 23 0 0 00000000 0 0 0 0 0 00 00000030
sll_reg      alu  6 21 80000001 22 0000001f 00000000 0 24 0 0 00000000 0 0 0 0 0 00 80000000
fwd_mem      alu  0 5  00001000 6  00000011 00000000 0 25 1 0 00000000 0 0 0 0 0 00 00001011
fwd_wb       alu  1 7  00000100 0  00000000 00000001 1 26 2 0 00000000 0 0 0 0 0 00 000000ff
fwd_mem_both alu  0 9  12345678 9  00000000 00000000 0 27 1 0 00000000 0 0 0 0 0 00 2468acf0
fwd_wb_both  alu  3 12 0f0f0000 12 00000000 00000000 0 28 2 0 00000000 0 0 0 0 0 00 0f0f0000
r0_no_fwd    alu  0 0  0000abcd 2  00000003 00000000 0 29 1 0 00000000 0 0 0 0 0 00 00000003
load_imm     lsu  0 3  00002000 4  cafef00d 00000010 1 5  0 3 89abcdef 0 0 0 0 0 00 89abcdef
load_reg_off lsu  0 6  00004000 7  00000024 00000000 0 8  0 1 00000042 0 0 0 0 0 00 00000042
load_long    lsu  0 1  00000100 2  00000200 fffffffc 1 9  0 7 13579bdf 0 0 0 0 0 00 13579bdf
intr_timer   intr 0 1  00000001 2  00000002 00000000 0 10 0 0 00000000 1 0 1 0 0 3f 00000000
intr_ext_lsu intr 0 3  00001000 4  00000000 00000008 1 11 0 2 00000000 0 1 1 0 0 05 00000000
exc_plain    exc  0 1  00000000 2  00000000 00000000 0 12 0 0 00000000 1 0 0 1 0 0b 0000000b
exc_ale      exc  0 5  00001001 6  00000000 00000000 1 13 0 2 00000000 0 1 0 0 1 09 00000009

// ==== sim.f ====
exu_pkg.sv
exu_bypass.sv
exu_alu.sv
exu_commit.sv
exu_trap_ctrl.sv
exu_top.sv
tb_exu.sv
